// File: design/arcade_pkg.sv
package arcade_pkg;

  // bus and video widths
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_data_t;
  typedef logic [9:0]  scanline_t;
  typedef logic [15:0] scroll_t;    // {high byte, low byte}
  typedef logic [1:0]  pal_bank_t;
  typedef logic [11:0] ram_addr_t;  // offset into 4 KB work RAM

  typedef enum logic [1:0] {
    IRQ_IDLE,
    IRQ_FRAME_PEND,
    IRQ_SOUND_PEND
  } irq_state_t;

  // main CPU memory map
  localparam cpu_addr_t RAM_BASE        = 16'he000;
  localparam cpu_addr_t RAM_LIMIT       = 16'hf000;  // first address past RAM
  localparam cpu_addr_t SYS_PORT_ADDR   = 16'hc000;
  localparam cpu_addr_t P1_PORT_ADDR    = 16'hc001;
  localparam cpu_addr_t P2_PORT_ADDR    = 16'hc002;
  localparam cpu_addr_t DSWA_ADDR       = 16'hc003;
  localparam cpu_addr_t DSWB_ADDR       = 16'hc004;
  localparam cpu_addr_t SOUNDLATCH_ADDR = 16'hc800;  // base of register block
  localparam cpu_addr_t SCROLL_LO_ADDR  = 16'hc802;
  localparam cpu_addr_t SCROLL_HI_ADDR  = 16'hc803;
  localparam cpu_addr_t SPARE_REG_ADDR  = 16'hc804;
  localparam cpu_addr_t PAL_BANK_ADDR   = 16'hc805;

  // scanline interrupts, request window is LINE up to END
  localparam scanline_t FRAME_IRQ_LINE = 10'd479;
  localparam scanline_t FRAME_IRQ_END  = 10'd481;
  localparam scanline_t SOUND_IRQ_LINE = 10'd240;
  localparam scanline_t SOUND_IRQ_END  = 10'd242;

  // mode 0 vectors, rst 10h and rst 08h
  localparam cpu_data_t FRAME_IRQ_VECTOR = 8'hd7;
  localparam cpu_data_t SOUND_IRQ_VECTOR = 8'hcf;

endpackage

// File: design/work_ram.sv
`timescale 1ns/100ps

module work_ram (
  input  logic                  cpu_clk,
  input  logic                  ram_write,
  input  arcade_pkg::ram_addr_t ram_addr,
  input  arcade_pkg::cpu_data_t cpu_data_in,
  output arcade_pkg::cpu_data_t ram_rdata
);

  import arcade_pkg::*;

  // 4 KB main CPU scratch RAM at e000-efff
  cpu_data_t mem [0:(1 << $bits(ram_addr_t)) - 1];

  // single port, write and registered read share the address
  always_ff @(posedge cpu_clk) begin
    if (ram_write) begin
      mem[ram_addr] <= cpu_data_in;
    end
    ram_rdata <= mem[ram_addr];  // old data on a same-cycle write
  end

endmodule

// File: design/control_regs.sv
`timescale 1ns/100ps

module control_regs (
  input  logic                  cpu_clk,
  input  logic                  rst_b,
  input  logic                  reg_write,
  input  logic [2:0]            reg_sel,
  input  arcade_pkg::cpu_data_t cpu_data_in,
  output arcade_pkg::cpu_data_t reg_rdata,
  output arcade_pkg::cpu_data_t soundlatch,
  output arcade_pkg::scroll_t   scroll_data,
  output arcade_pkg::pal_bank_t palette_bank
);

  import arcade_pkg::*;

  cpu_data_t latch_q;      // c800, command byte for the sound CPU
  cpu_data_t scroll_lo_q;  // c802
  cpu_data_t scroll_hi_q;  // c803
  cpu_data_t spare_q;      // c804, no known use on the board
  cpu_data_t pal_q;        // c805, only low two bits reach video

  // offsets within c800-c805 come from the low address bits
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      latch_q     <= '0;
      scroll_lo_q <= '0;
      scroll_hi_q <= '0;
      spare_q     <= '0;
      pal_q       <= '0;
    end else if (reg_write) begin
      case (reg_sel)
        SOUNDLATCH_ADDR[2:0]: latch_q     <= cpu_data_in;
        SCROLL_LO_ADDR[2:0]:  scroll_lo_q <= cpu_data_in;
        SCROLL_HI_ADDR[2:0]:  scroll_hi_q <= cpu_data_in;
        SPARE_REG_ADDR[2:0]:  spare_q     <= cpu_data_in;
        PAL_BANK_ADDR[2:0]:   pal_q       <= cpu_data_in;
        default: ;  // c801 has no register
      endcase
    end
  end

  // read-back, memory_map adds the pipeline stage
  always_comb begin
    case (reg_sel)
      SOUNDLATCH_ADDR[2:0]: reg_rdata = latch_q;
      SCROLL_LO_ADDR[2:0]:  reg_rdata = scroll_lo_q;
      SCROLL_HI_ADDR[2:0]:  reg_rdata = scroll_hi_q;
      SPARE_REG_ADDR[2:0]:  reg_rdata = spare_q;
      PAL_BANK_ADDR[2:0]:   reg_rdata = pal_q;
      default:              reg_rdata = '0;
    endcase
  end

  assign soundlatch   = latch_q;
  assign scroll_data  = {scroll_hi_q, scroll_lo_q};
  assign palette_bank = pal_q[1:0];

  // decoder must not strobe past the last register
  a_reg_sel_range: assert property (
    @(posedge cpu_clk) disable iff (!rst_b)
    reg_write |-> (reg_sel <= PAL_BANK_ADDR[2:0])
  );

endmodule

// File: design/memory_map.sv
`timescale 1ns/100ps

module memory_map (
  input  logic                  cpu_clk,
  input  logic                  rst_b,
  input  arcade_pkg::cpu_addr_t cpu_address,
  input  logic                  cpu_write,
  input  logic                  up,
  input  logic                  down,
  input  logic                  left,
  input  logic                  right,
  input  logic                  fire,
  input  logic                  special,
  input  logic                  p1_start,
  input  logic                  p2_start,
  input  logic                  coin,
  input  arcade_pkg::cpu_data_t dip,
  input  arcade_pkg::cpu_data_t ram_rdata,
  input  arcade_pkg::cpu_data_t reg_rdata,
  input  logic                  irq_ack,
  input  arcade_pkg::cpu_data_t irq_vector,
  output logic                  ram_write,
  output arcade_pkg::ram_addr_t ram_addr,
  output logic                  reg_write,
  output logic [2:0]            reg_sel,
  output arcade_pkg::cpu_data_t cpu_data_out
);

  import arcade_pkg::*;

  logic      in_ram;
  logic      in_regs;
  cpu_addr_t reg_offset;
  cpu_data_t ctrl_port;   // shared by both player ports
  cpu_data_t local_data;  // ports and registers, ready in the address cycle

  logic      sel_ram_q;
  logic      ack_q;
  cpu_data_t local_q;
  cpu_data_t vec_q;

  assign in_ram  = (cpu_address >= RAM_BASE) && (cpu_address < RAM_LIMIT);
  assign in_regs = (cpu_address >= SOUNDLATCH_ADDR) && (cpu_address <= PAL_BANK_ADDR);

  assign reg_offset = cpu_address - SOUNDLATCH_ADDR;
  assign reg_sel    = reg_offset[2:0];
  assign ram_addr   = cpu_address[11:0];

  assign ram_write = cpu_write & in_ram;
  assign reg_write = cpu_write & in_regs;

  // all inputs active low, unused bits float high
  assign ctrl_port = ~{2'b00, special, fire, up, down, right, left};

  always_comb begin
    case (cpu_address)
      SYS_PORT_ADDR: local_data = ~{coin, 5'b00000, p2_start, p1_start};
      P1_PORT_ADDR:  local_data = ctrl_port;
      P2_PORT_ADDR:  local_data = ctrl_port;
      DSWA_ADDR:     local_data = 8'hff;
      DSWB_ADDR:     local_data = ~{4'b0000, dip[0], 3'b000};  // test mode switch
      default:       local_data = in_regs ? reg_rdata : '0;  // dropped regions read 00
    endcase
  end

  // first stage, lines everything up with the RAM read latency
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      sel_ram_q <= 1'b0;
      ack_q     <= 1'b0;
      local_q   <= '0;
      vec_q     <= '0;
    end else begin
      sel_ram_q <= in_ram;
      ack_q     <= irq_ack;
      local_q   <= local_data;
      vec_q     <= irq_vector;
    end
  end

  // second stage, vector wins during an interrupt acknowledge
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      cpu_data_out <= '0;
    end else if (ack_q) begin
      cpu_data_out <= vec_q;
    end else if (sel_ram_q) begin
      cpu_data_out <= ram_rdata;
    end else begin
      cpu_data_out <= local_q;
    end
  end

  a_one_write_target: assert property (
    @(posedge cpu_clk) disable iff (!rst_b)
    !(ram_write && reg_write)
  );

endmodule

// File: design/irq_controller.sv
`timescale 1ns/100ps

module irq_controller (
  input  logic                  cpu_clk,
  input  logic                  rst_b,
  input  arcade_pkg::scanline_t scanline,
  input  logic                  m1_n,
  input  logic                  iorq_n,
  output logic                  int_n,
  output logic                  irq_ack,
  output arcade_pkg::cpu_data_t irq_vector
);

  import arcade_pkg::*;

  scanline_t  line_meta;
  scanline_t  line_sync;
  irq_state_t state;
  irq_state_t state_next;
  logic       frame_done;  // frame irq taken in this window
  logic       sound_done;
  logic       ack_cycle;

  // scanline comes from the video clock, two flop synchronizer
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      line_meta <= '0;
      line_sync <= '0;
    end else begin
      line_meta <= scanline;
      line_sync <= line_meta;
    end
  end

  assign ack_cycle  = ~m1_n & ~iorq_n;  // z80 int acknowledge
  assign irq_ack    = ack_cycle & (state != IRQ_IDLE);
  assign irq_vector = (state == IRQ_FRAME_PEND) ? FRAME_IRQ_VECTOR : SOUND_IRQ_VECTOR;

  always_comb begin
    state_next = state;
    case (state)
      IRQ_IDLE: begin
        if (line_sync == FRAME_IRQ_LINE && !frame_done) begin
          state_next = IRQ_FRAME_PEND;
        end else if (line_sync == SOUND_IRQ_LINE && !sound_done) begin
          state_next = IRQ_SOUND_PEND;
        end
      end
      IRQ_FRAME_PEND: begin
        if (ack_cycle || line_sync == FRAME_IRQ_END) begin
          state_next = IRQ_IDLE;  // taken, or window closed
        end
      end
      IRQ_SOUND_PEND: begin
        if (ack_cycle || line_sync == SOUND_IRQ_END) begin
          state_next = IRQ_IDLE;
        end
      end
      default: state_next = IRQ_IDLE;
    endcase
  end

  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= IRQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // done flags stop a second request while the line is still held
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      frame_done <= 1'b0;
      sound_done <= 1'b0;
    end else begin
      if (line_sync == FRAME_IRQ_END) begin
        frame_done <= 1'b0;
      end else if (irq_ack && state == IRQ_FRAME_PEND) begin
        frame_done <= 1'b1;
      end
      if (line_sync == SOUND_IRQ_END) begin
        sound_done <= 1'b0;
      end else if (irq_ack && state == IRQ_SOUND_PEND) begin
        sound_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      int_n <= 1'b1;
    end else begin
      int_n <= (state == IRQ_IDLE);
    end
  end

  // a taken frame request stays quiet while the line is held
  a_no_refire_while_held: assert property (
    @(posedge cpu_clk) disable iff (!rst_b)
    frame_done && line_sync == FRAME_IRQ_LINE |=> int_n
  );

endmodule

// File: design/arcade_main.sv
`timescale 1ns/100ps

module arcade_main (
  input  logic                  cpu_clk,
  input  logic                  rst_b,
  input  arcade_pkg::cpu_addr_t cpu_address,
  input  arcade_pkg::cpu_data_t cpu_data_in,
  input  logic                  cpu_write,
  input  logic                  m1_n,
  input  logic                  iorq_n,
  input  arcade_pkg::scanline_t scanline,
  input  logic                  up,
  input  logic                  down,
  input  logic                  left,
  input  logic                  right,
  input  logic                  fire,
  input  logic                  special,
  input  logic                  p1_start,
  input  logic                  p2_start,
  input  logic                  coin,
  input  arcade_pkg::cpu_data_t dip,
  output arcade_pkg::cpu_data_t cpu_data_out,
  output logic                  int_n,
  output arcade_pkg::cpu_data_t soundlatch,
  output arcade_pkg::scroll_t   scroll_data,
  output arcade_pkg::pal_bank_t palette_bank
);

  import arcade_pkg::*;

  logic       ram_write;
  ram_addr_t  ram_addr;
  cpu_data_t  ram_rdata;
  logic       reg_write;
  logic [2:0] reg_sel;
  cpu_data_t  reg_rdata;
  logic       irq_ack;
  cpu_data_t  irq_vector;

  memory_map i_memory_map (
    .cpu_clk     (cpu_clk),
    .rst_b       (rst_b),
    .cpu_address (cpu_address),
    .cpu_write   (cpu_write),
    .up          (up),
    .down        (down),
    .left        (left),
    .right       (right),
    .fire        (fire),
    .special     (special),
    .p1_start    (p1_start),
    .p2_start    (p2_start),
    .coin        (coin),
    .dip         (dip),
    .ram_rdata   (ram_rdata),
    .reg_rdata   (reg_rdata),
    .irq_ack     (irq_ack),
    .irq_vector  (irq_vector),
    .ram_write   (ram_write),
    .ram_addr    (ram_addr),
    .reg_write   (reg_write),
    .reg_sel     (reg_sel),
    .cpu_data_out(cpu_data_out)
  );

  work_ram i_work_ram (
    .cpu_clk    (cpu_clk),
    .ram_write  (ram_write),
    .ram_addr   (ram_addr),
    .cpu_data_in(cpu_data_in),
    .ram_rdata  (ram_rdata)
  );

  control_regs i_control_regs (
    .cpu_clk     (cpu_clk),
    .rst_b       (rst_b),
    .reg_write   (reg_write),
    .reg_sel     (reg_sel),
    .cpu_data_in (cpu_data_in),
    .reg_rdata   (reg_rdata),
    .soundlatch  (soundlatch),
    .scroll_data (scroll_data),
    .palette_bank(palette_bank)
  );

  irq_controller i_irq_controller (
    .cpu_clk   (cpu_clk),
    .rst_b     (rst_b),
    .scanline  (scanline),
    .m1_n      (m1_n),
    .iorq_n    (iorq_n),
    .int_n     (int_n),
    .irq_ack   (irq_ack),
    .irq_vector(irq_vector)
  );

endmodule

// File: verif/arcade_main_checks.sv
`timescale 1ns/100ps

module arcade_main_checks (
  input  logic                  cpu_clk,
  input  logic                  rst_b,
  input  arcade_pkg::cpu_addr_t cpu_address,
  input  arcade_pkg::cpu_data_t cpu_data_in,
  input  logic                  cpu_write,
  input  logic                  m1_n,
  input  logic                  iorq_n,
  input  arcade_pkg::scanline_t scanline,
  input  logic [8:0]            buttons,  // {coin, p2_start, p1_start, special, fire, up, down, right, left}
  input  arcade_pkg::cpu_data_t dip,
  input  arcade_pkg::cpu_data_t cpu_data_out,
  input  logic                  int_n,
  input  arcade_pkg::cpu_data_t soundlatch,
  input  arcade_pkg::scroll_t   scroll_data,
  input  arcade_pkg::pal_bank_t palette_bank,
  output logic                  failed
);

  import arcade_pkg::*;

  cpu_data_t   sh_ram [0:4095];
  logic [4095:0] known;  // ram bytes written so far
  cpu_data_t   sh_reg [0:7];
  cpu_data_t   exp_now, exp_q1, exp_q2;
  logic        ok_now, ok_q1, ok_q2;
  logic        ack, frame_taken, sound_taken;

  initial failed = 1'b0;

  assign ack = !m1_n && !iorq_n && !int_n;

  always_comb begin
    ok_now  = 1'b1;
    exp_now = 8'h00;  // unmapped space
    if (ack) begin
      exp_now = (scanline == FRAME_IRQ_LINE) ? FRAME_IRQ_VECTOR : SOUND_IRQ_VECTOR;
    end else if (cpu_address >= RAM_BASE && cpu_address < RAM_LIMIT) begin
      ok_now  = known[cpu_address[11:0]];
      exp_now = sh_ram[cpu_address[11:0]];
    end else if (cpu_address >= SOUNDLATCH_ADDR && cpu_address <= PAL_BANK_ADDR) begin
      exp_now = sh_reg[cpu_address[2:0]];
    end else begin
      case (cpu_address)
        SYS_PORT_ADDR: exp_now = {~buttons[8], 5'b11111, ~buttons[7], ~buttons[6]};
        P1_PORT_ADDR, P2_PORT_ADDR: exp_now = {2'b11, ~buttons[5:0]};
        DSWA_ADDR:     exp_now = 8'hff;
        DSWB_ADDR:     exp_now = {4'hf, ~dip[0], 3'b111};
        default: ;
      endcase
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (cpu_write && cpu_address >= RAM_BASE && cpu_address < RAM_LIMIT) begin
      sh_ram[cpu_address[11:0]] <= cpu_data_in;
    end
  end

  // shadow registers, read pipeline and interrupt bookkeeping
  always_ff @(posedge cpu_clk or negedge rst_b) begin
    if (!rst_b) begin
      known <= '0;
      for (int i = 0; i < 8; i++) sh_reg[i] <= 8'h00;
      {ok_q1, ok_q2, exp_q1, exp_q2} <= '0;
      {frame_taken, sound_taken} <= 2'b00;
    end else begin
      if (cpu_write && cpu_address >= RAM_BASE && cpu_address < RAM_LIMIT) begin
        known[cpu_address[11:0]] <= 1'b1;
      end
      if (cpu_write && cpu_address >= SOUNDLATCH_ADDR && cpu_address <= PAL_BANK_ADDR &&
          cpu_address != SOUNDLATCH_ADDR + 1) begin
        sh_reg[cpu_address[2:0]] <= cpu_data_in;
      end
      {ok_q1, exp_q1} <= {ok_now, exp_now};
      {ok_q2, exp_q2} <= {ok_q1, exp_q1};
      if (scanline == FRAME_IRQ_END) frame_taken <= 1'b0;
      else if (ack && scanline == FRAME_IRQ_LINE) frame_taken <= 1'b1;
      if (scanline == SOUND_IRQ_END) sound_taken <= 1'b0;
      else if (ack && scanline == SOUND_IRQ_LINE) sound_taken <= 1'b1;
    end
  end

  // first edge after reset release
  a_reset_values: assert property (@(posedge cpu_clk)
    $rose(rst_b) |-> int_n && cpu_data_out == 0 && soundlatch == 0 && scroll_data == 0
                     && palette_bank == 0)
    else begin
      $display("** Error: after reset int_n = %h cpu_data_out = %h soundlatch = %h",
               $sampled(int_n), $sampled(cpu_data_out), $sampled(soundlatch));
      $display("** Error: after reset scroll_data = %h palette_bank = %h",
               $sampled(scroll_data), $sampled(palette_bank));
      failed = 1'b1;
    end

  a_read_data: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    ok_q2 |-> cpu_data_out == exp_q2)
    else begin
      $display("** Error: cpu_data_out = %h, expected %h", $sampled(cpu_data_out),
               $sampled(exp_q2));
      failed = 1'b1;
    end

  a_reg_outputs: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    soundlatch == sh_reg[0] && scroll_data == {sh_reg[3], sh_reg[2]}
    && palette_bank == sh_reg[5][1:0])
    else begin
      $display("** Error: soundlatch = %h scroll_data = %h palette_bank = %h, expected %h %h %h",
               $sampled(soundlatch), $sampled(scroll_data), $sampled(palette_bank),
               $sampled(sh_reg[0]), {$sampled(sh_reg[3]), $sampled(sh_reg[2])},
               $sampled(sh_reg[5][1:0]));
      failed = 1'b1;
    end

  a_irq_fires: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    int_n && ((scanline == FRAME_IRQ_LINE && !frame_taken) ||
              (scanline == SOUND_IRQ_LINE && !sound_taken)) |-> ##[1:4] !int_n)
    else begin
      $display("int_n did not fall within four cycles of an interrupt line");
      failed = 1'b1;
    end

  a_ack_releases: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    ack |-> ##2 int_n)
    else begin
      $display("int_n still low two cycles after the acknowledge");
      failed = 1'b1;
    end

  a_no_refire: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    frame_taken && $past(frame_taken) && scanline == FRAME_IRQ_LINE |-> int_n)
    else begin
      $display("frame interrupt fired again before line 481");
      failed = 1'b1;
    end

  a_window_close: assert property (@(posedge cpu_clk) disable iff (!rst_b)
    (scanline == FRAME_IRQ_END || scanline == SOUND_IRQ_END) |-> ##[1:4] int_n)
    else begin
      $display("interrupt request not withdrawn after its window closed");
      failed = 1'b1;
    end

endmodule

// File: verif/arcade_main_tb.sv
`timescale 1ns/100ps

module arcade_main_tb;

  import arcade_pkg::*;

  logic cpu_clk, rst_b, cpu_write, m1_n, iorq_n;
  logic up, down, left, right, fire, special, p1_start, p2_start, coin;
  cpu_addr_t cpu_address;
  cpu_data_t cpu_data_in, dip, cpu_data_out, soundlatch;
  scanline_t scanline;
  scroll_t   scroll_data;
  pal_bank_t palette_bank;
  logic      int_n, check_failed;
  int        cycles;
  cpu_addr_t ram_list [0:199];

  arcade_main i_arcade_main (.*);

  arcade_main_checks i_arcade_main_checks (
    .cpu_clk(cpu_clk), .rst_b(rst_b), .cpu_address(cpu_address),
    .cpu_data_in(cpu_data_in), .cpu_write(cpu_write), .m1_n(m1_n), .iorq_n(iorq_n),
    .scanline(scanline),
    .buttons({coin, p2_start, p1_start, special, fire, up, down, right, left}),
    .dip(dip), .cpu_data_out(cpu_data_out), .int_n(int_n), .soundlatch(soundlatch),
    .scroll_data(scroll_data), .palette_bank(palette_bank), .failed(check_failed)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #50 cpu_clk = ~cpu_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  always @(posedge check_failed) abort_run("a bus check failed");

  // run limit, far above what the tests need
  always @(posedge cpu_clk) begin
    cycles <= cycles + 1;
    if (cycles >= 20000) abort_run("timeout, run did not finish in 20000 cycles");
  end

  task automatic step(input int n = 1);
    repeat (n) begin
      @(posedge cpu_clk);
      #10;
    end
  endtask

  task automatic bus_write(input cpu_addr_t a, input cpu_data_t d);
    cpu_address = a;
    cpu_data_in = d;
    cpu_write   = 1'b1;
    step();
    cpu_write   = 1'b0;
  endtask

  task automatic bus_read(input cpu_addr_t a);
    cpu_address = a;
    step();
  endtask

  task automatic wait_int(input logic level);
    int n;
    n = 0;
    while (int_n !== level) begin
      if (n == 8) abort_run("int_n did not reach the expected level in time");
      n++;
      step();
    end
  endtask

  task automatic acknowledge();
    cpu_address = 16'h0000;
    m1_n   = 1'b0;
    iorq_n = 1'b0;
    step();
    {m1_n, iorq_n} = 2'b11;
    step(3);
  endtask

  initial begin
    cycles = 0;
    void'($urandom(32'hf5fd_9890));
    {rst_b, cpu_write} = 2'b00;
    {m1_n, iorq_n} = 2'b11;
    {up, down, left, right, fire, special, p1_start, p2_start, coin} = '0;
    cpu_address = 16'h0000;
    cpu_data_in = 8'h00;
    dip         = 8'h00;
    scanline    = 10'd0;
    repeat (5) @(posedge cpu_clk);
    #10 rst_b = 1'b1;
    step(2);

    for (int i = 0; i < 200; i++) begin
      ram_list[i] = RAM_BASE + ($urandom % 4096);
      bus_write(ram_list[i], $urandom);
    end
    for (int i = 0; i < 200; i++) bus_read(ram_list[i]);
    for (int i = 0; i < 50; i++) begin
      bus_read($urandom % 16'hc000);
      bus_read(16'hcc00 + ($urandom % 16'h1000));  // cc00-dbff
    end

    for (int i = 0; i < 40; i++) begin
      cpu_addr_t a;
      a = SOUNDLATCH_ADDR + 2 + ($urandom % 4);
      if (i % 5 == 0) a = SOUNDLATCH_ADDR;
      bus_write(a, $urandom);
      bus_read(a);
    end

    for (int i = 0; i < 50; i++) begin
      {up, down, left, right, fire, special, p1_start, p2_start, coin} = $urandom;
      dip = $urandom;
      for (int p = 0; p < 5; p++) bus_read(SYS_PORT_ADDR + p);
    end

    // frame interrupt, then no refire until line 481 passes
    scanline = FRAME_IRQ_LINE;
    wait_int(1'b0);
    acknowledge();
    step(20);
    scanline = 10'd480;
    step(4);
    scanline = FRAME_IRQ_END;
    step(6);
    scanline = FRAME_IRQ_LINE;
    wait_int(1'b0);
    acknowledge();
    scanline = FRAME_IRQ_END;
    step(6);

    // sound interrupt taken, then left to expire
    scanline = SOUND_IRQ_LINE;
    wait_int(1'b0);
    acknowledge();
    scanline = SOUND_IRQ_END;
    step(6);
    scanline = SOUND_IRQ_LINE;
    wait_int(1'b0);
    step(5);
    scanline = SOUND_IRQ_END;
    wait_int(1'b1);
    step(6);

    if (check_failed) begin
      abort_run("a bus check failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: arcade_main.f
design/arcade_pkg.sv
design/work_ram.sv
design/control_regs.sv
design/memory_map.sv
design/irq_controller.sv
design/arcade_main.sv
verif/arcade_main_checks.sv
verif/arcade_main_tb.sv
